// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes, rv32i subset
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    localparam int alu_op_w = 3;
    localparam logic [alu_op_w-1:0] alu_add = 3'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
    localparam logic [alu_op_w-1:0] alu_and = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
    localparam logic [alu_op_w-1:0] alu_slt = 3'd4;

    localparam int imm_sel_w = 3;
    localparam logic [imm_sel_w-1:0] imm_i = 3'd0;
    localparam logic [imm_sel_w-1:0] imm_s = 3'd1;
    localparam logic [imm_sel_w-1:0] imm_b = 3'd2;
    localparam logic [imm_sel_w-1:0] imm_u = 3'd3;
    localparam logic [imm_sel_w-1:0] imm_j = 3'd4;

    // writeback sources
    localparam int wb_sel_w = 2;
    localparam logic [wb_sel_w-1:0] wb_alu = 2'd0;
    localparam logic [wb_sel_w-1:0] wb_mem = 2'd1;
    localparam logic [wb_sel_w-1:0] wb_pc4 = 2'd2; // link value of jal
    localparam logic [wb_sel_w-1:0] wb_imm = 2'd3; // lui

    localparam int fwd_w = 2;
    localparam logic [fwd_w-1:0] fwd_none = 2'b00;
    localparam logic [fwd_w-1:0] fwd_wb   = 2'b01;
    localparam logic [fwd_w-1:0] fwd_mem  = 2'b10;

    // one instruction word, six field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

// File: logic/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
    input  rv_pkg::rv_instr_u              instr,
    output logic                           reg_write,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic                           alu_src_imm,
    output logic                           branch,
    output logic                           jump,
    output logic [rv_pkg::alu_op_w-1:0]    alu_op,
    output logic [rv_pkg::imm_sel_w-1:0]   imm_sel,
    output logic [rv_pkg::wb_sel_w-1:0]    wb_sel
);

    always_comb begin
        // unknown opcodes fall through with nothing enabled
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        alu_op      = rv_pkg::alu_add;
        imm_sel     = rv_pkg::imm_i;
        wb_sel      = rv_pkg::wb_alu;

        case (instr.r.opcode)
            rv_pkg::op_r: begin
                reg_write = 1'b1;
                case (instr.r.funct3)
                    3'b000:  alu_op = instr.r.funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    3'b111:  alu_op = rv_pkg::alu_and;
                    default: reg_write = 1'b0; // shifts, xor, sltu not built
                endcase
            end
            rv_pkg::op_imm: begin
                reg_write   = (instr.i.funct3 == 3'b000); // addi only
                alu_src_imm = 1'b1;
            end
            rv_pkg::op_load: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = rv_pkg::wb_mem;
            end
            rv_pkg::op_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm_sel     = rv_pkg::imm_s;
            end
            rv_pkg::op_branch: begin
                branch  = (instr.b.funct3 == 3'b000); // beq
                imm_sel = rv_pkg::imm_b;
            end
            rv_pkg::op_lui: begin
                reg_write = 1'b1;
                imm_sel   = rv_pkg::imm_u;
                wb_sel    = rv_pkg::wb_imm;
            end
            rv_pkg::op_jal: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                imm_sel   = rv_pkg::imm_j;
                wb_sel    = rv_pkg::wb_pc4;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_pkg::rv_instr_u              instr,
    input  logic [rv_pkg::imm_sel_w-1:0]   imm_sel,
    output logic [rv_pkg::xlen-1:0]        imm,
    output logic [rv_pkg::xlen-1:0]        imm_b,   // to the decode branch adder
    output logic [rv_pkg::xlen-1:0]        imm_j    // to the decode jal adder
);

    logic [rv_pkg::xlen-1:0] ext_i;
    logic [rv_pkg::xlen-1:0] ext_s;
    logic [rv_pkg::xlen-1:0] ext_u;

    assign ext_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign ext_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign ext_u = {instr.u.imm_31_12, 12'b0}; // low bits zero filled

    // halfword offsets, bit 0 always zero
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_s: imm = ext_s;
            rv_pkg::imm_b: imm = imm_b;
            rv_pkg::imm_u: imm = ext_u;
            rv_pkg::imm_j: imm = imm_j;
            default:       imm = ext_i;
        endcase
    end

endmodule

// File: logic/rv_reg_file.sv
`timescale 1ns/100ps

module rv_reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0]   ra1,
    input  logic [rv_pkg::reg_addr_w-1:0]   ra2,
    output logic [rv_pkg::xlen-1:0]         rd1,
    output logic [rv_pkg::xlen-1:0]         rd2,
    input  logic                            we,
    input  logic [rv_pkg::reg_addr_w-1:0]   wa,
    input  logic [rv_pkg::xlen-1:0]         wd
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];
    logic                    wr_live; // a real write this cycle

    assign wr_live = we && (wa != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 2**rv_pkg::reg_addr_w; k++)
                regs[k] <= '0;
        end else if (wr_live) begin
            regs[wa] <= wd;             // x0 never written
        end
    end

    // writeback in the same cycle wins over the stored value
    assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

// File: logic/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0]       a,
    input  logic [rv_pkg::xlen-1:0]       b,
    input  logic [rv_pkg::alu_op_w-1:0]   alu_op,
    output logic [rv_pkg::xlen-1:0]       y
);

    logic lt; // signed compare

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub: y = a - b;
            rv_pkg::alu_and: y = a & b;
            rv_pkg::alu_or:  y = a | b;
            rv_pkg::alu_slt: y = {{(rv_pkg::xlen-1){1'b0}}, lt};
            default:         y = a + b;  // add, also address calc
        endcase
    end

endmodule

// File: logic/rv_hazard_unit.sv
`timescale 1ns/100ps

module rv_hazard_unit (
    input  logic [rv_pkg::reg_addr_w-1:0]   rs1_d,
    input  logic [rv_pkg::reg_addr_w-1:0]   rs2_d,
    input  logic [rv_pkg::reg_addr_w-1:0]   rs1_e,
    input  logic [rv_pkg::reg_addr_w-1:0]   rs2_e,
    input  logic [rv_pkg::reg_addr_w-1:0]   rd_e,
    input  logic [rv_pkg::reg_addr_w-1:0]   rd_m,
    input  logic [rv_pkg::reg_addr_w-1:0]   rd_w,
    input  logic                            reg_write_e,
    input  logic                            reg_write_m,
    input  logic                            reg_write_w,
    input  logic                            mem_read_e,
    input  logic                            mem_read_m,
    input  logic                            branch_d,
    output logic [rv_pkg::fwd_w-1:0]        fwd_a_e,
    output logic [rv_pkg::fwd_w-1:0]        fwd_b_e,
    output logic                            fwd_a_d,
    output logic                            fwd_b_d,
    output logic                            stall_fd,
    output logic                            flush_de
);

    logic lw_stall;
    logic br_stall;

    // newest producer first, memory before writeback
    function automatic logic [rv_pkg::fwd_w-1:0] pick_fwd(
        input logic [rv_pkg::reg_addr_w-1:0] rs
    );
        if (rs != '0 && reg_write_m && rd_m == rs)
            return rv_pkg::fwd_mem;
        if (rs != '0 && reg_write_w && rd_w == rs)
            return rv_pkg::fwd_wb;
        return rv_pkg::fwd_none;
    endfunction

    // rd is a live destination read by the decode instruction
    function automatic logic feeds_d(input logic [rv_pkg::reg_addr_w-1:0] rd);
        return (rd != '0) && (rd == rs1_d || rd == rs2_d);
    endfunction

    always_comb begin
        fwd_a_e  = pick_fwd(rs1_e);
        fwd_b_e  = pick_fwd(rs2_e);
        lw_stall = mem_read_e && feeds_d(rd_e);
        // branch compares in decode, so anything not yet in memory must wait
        br_stall = branch_d && ((reg_write_e && feeds_d(rd_e)) ||
                                (mem_read_m && feeds_d(rd_m)));
    end

    assign fwd_a_d  = reg_write_m && (rd_m != '0) && (rd_m == rs1_d);
    assign fwd_b_d  = reg_write_m && (rd_m != '0) && (rd_m == rs2_d);
    assign stall_fd = lw_stall | br_stall;
    assign flush_de = lw_stall | br_stall;  // bubble into execute

endmodule

// File: logic/rv_core.sv
`timescale 1ns/100ps

module rv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv_pkg::xlen-1:0]   imem_addr,
    input  logic [rv_pkg::xlen-1:0]   imem_data,
    output logic [rv_pkg::xlen-1:0]   dmem_addr,
    output logic [rv_pkg::xlen-1:0]   dmem_wdata,
    output logic                      dmem_we,
    input  logic [rv_pkg::xlen-1:0]   dmem_rdata
);

    logic [rv_pkg::xlen-1:0] pc_f, pc_next;
    rv_pkg::rv_instr_u       instr_d;
    logic [rv_pkg::xlen-1:0] pc_d, pc4_d, rd1_d, rd2_d, imm_d, imm_b_d, imm_j_d;
    logic [rv_pkg::xlen-1:0] cmp_a_d, cmp_b_d;
    logic                    reg_write_d, mem_read_d, mem_write_d, alu_src_d;
    logic                    branch_d, jump_d, taken_d;
    logic [rv_pkg::alu_op_w-1:0]  alu_op_d, alu_op_e;
    logic [rv_pkg::imm_sel_w-1:0] imm_sel_d;
    logic [rv_pkg::wb_sel_w-1:0]  wb_sel_d, wb_sel_e, wb_sel_m, wb_sel_w;
    logic [rv_pkg::xlen-1:0] rd1_e, rd2_e, imm_e, pc4_e, src_a_e, src_b_e, alu_b_e, alu_y_e;
    logic [rv_pkg::reg_addr_w-1:0] rs1_e, rs2_e, rd_e, rd_m, rd_w;
    logic                    reg_write_e, mem_read_e, mem_write_e, alu_src_e;
    logic [rv_pkg::xlen-1:0] alu_m, wdata_m, pc4_m, imm_m, result_m;
    logic                    reg_write_m, mem_read_m, mem_write_m;
    logic [rv_pkg::xlen-1:0] alu_w, pc4_w, imm_w, wd_w;
    logic                    reg_write_w;
    logic [rv_pkg::fwd_w-1:0] fwd_a_e, fwd_b_e;
    logic                    fwd_a_d, fwd_b_d, stall_fd, flush_de;

    ////////////////////////////////////////////////////////////////////////////
    // fetch

    always_comb begin
        if (taken_d)
            pc_next = pc_d + imm_b_d;       // target from the branch's own pc
        else if (jump_d)
            pc_next = pc_d + imm_j_d;
        else
            pc_next = pc_f + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc_f <= rv_pkg::reset_pc;
        else if (!stall_fd)
            pc_f <= pc_next;
    end

    assign imem_addr = pc_f;

    always_ff @(posedge clk) begin
        if (!rst_n)
            instr_d <= '0;
        else if (!stall_fd)
            instr_d <= (taken_d || jump_d) ? '0 : imem_data; // kill wrong-path fetch
    end

    always_ff @(posedge clk) begin
        if (!stall_fd)
            pc_d <= pc_f;
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode

    rv_decoder u_decoder (
        .instr       (instr_d),
        .reg_write   (reg_write_d),
        .mem_read    (mem_read_d),
        .mem_write   (mem_write_d),
        .alu_src_imm (alu_src_d),
        .branch      (branch_d),
        .jump        (jump_d),
        .alu_op      (alu_op_d),
        .imm_sel     (imm_sel_d),
        .wb_sel      (wb_sel_d)
    );

    rv_imm_gen u_imm_gen (
        .instr   (instr_d),
        .imm_sel (imm_sel_d),
        .imm     (imm_d),
        .imm_b   (imm_b_d),
        .imm_j   (imm_j_d)
    );

    rv_reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (instr_d.r.rs1),
        .ra2   (instr_d.r.rs2),
        .rd1   (rd1_d),
        .rd2   (rd2_d),
        .we    (reg_write_w),
        .wa    (rd_w),
        .wd    (wd_w)
    );

    assign cmp_a_d = fwd_a_d ? result_m : rd1_d;
    assign cmp_b_d = fwd_b_d ? result_m : rd2_d;
    assign taken_d = branch_d && (cmp_a_d == cmp_b_d);
    assign pc4_d   = pc_d + 32'd4;

    rv_hazard_unit u_hazard (
        .rs1_d       (instr_d.r.rs1),
        .rs2_d       (instr_d.r.rs2),
        .rs1_e       (rs1_e),
        .rs2_e       (rs2_e),
        .rd_e        (rd_e),
        .rd_m        (rd_m),
        .rd_w        (rd_w),
        .reg_write_e (reg_write_e),
        .reg_write_m (reg_write_m),
        .reg_write_w (reg_write_w),
        .mem_read_e  (mem_read_e),
        .mem_read_m  (mem_read_m),
        .branch_d    (branch_d),
        .fwd_a_e     (fwd_a_e),
        .fwd_b_e     (fwd_b_e),
        .fwd_a_d     (fwd_a_d),
        .fwd_b_d     (fwd_b_d),
        .stall_fd    (stall_fd),
        .flush_de    (flush_de)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || flush_de) begin   // bubble carries no writer
            {reg_write_e, mem_read_e, mem_write_e, alu_src_e} <= '0;
            alu_op_e <= rv_pkg::alu_add;
            wb_sel_e <= rv_pkg::wb_alu;
            {rs1_e, rs2_e, rd_e} <= '0;
        end else begin
            {reg_write_e, mem_read_e, mem_write_e, alu_src_e} <=
                {reg_write_d, mem_read_d, mem_write_d, alu_src_d};
            alu_op_e <= alu_op_d;
            wb_sel_e <= wb_sel_d;
            {rs1_e, rs2_e, rd_e} <= {instr_d.r.rs1, instr_d.r.rs2, instr_d.r.rd};
        end
    end

    always_ff @(posedge clk) begin
        rd1_e <= rd1_d;
        rd2_e <= rd2_d;
        imm_e <= imm_d;
        pc4_e <= pc4_d;
    end

    ////////////////////////////////////////////////////////////////////////////
    // execute

    function automatic logic [rv_pkg::xlen-1:0] fwd_pick(
        input logic [rv_pkg::fwd_w-1:0] sel,
        input logic [rv_pkg::xlen-1:0]  reg_val,
        input logic [rv_pkg::xlen-1:0]  mem_val,
        input logic [rv_pkg::xlen-1:0]  wb_val
    );
        case (sel)
            rv_pkg::fwd_mem: return mem_val;
            rv_pkg::fwd_wb:  return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    assign src_a_e = fwd_pick(fwd_a_e, rd1_e, result_m, wd_w);
    assign src_b_e = fwd_pick(fwd_b_e, rd2_e, result_m, wd_w); // also store data
    assign alu_b_e = alu_src_e ? imm_e : src_b_e;

    rv_alu u_alu (
        .a      (src_a_e),
        .b      (alu_b_e),
        .alu_op (alu_op_e),
        .y      (alu_y_e)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {reg_write_m, mem_read_m, mem_write_m} <= '0;
            wb_sel_m <= rv_pkg::wb_alu;
            rd_m     <= '0;
        end else begin
            {reg_write_m, mem_read_m, mem_write_m} <= {reg_write_e, mem_read_e, mem_write_e};
            wb_sel_m <= wb_sel_e;
            rd_m     <= rd_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_m   <= alu_y_e;
        wdata_m <= src_b_e;
        pc4_m   <= pc4_e;
        imm_m   <= imm_e;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory and writeback

    assign dmem_addr  = alu_m;
    assign dmem_wdata = wdata_m;
    assign dmem_we    = mem_write_m;

    // value forwarded out of memory, load data is not here yet
    always_comb begin
        case (wb_sel_m)
            rv_pkg::wb_pc4: result_m = pc4_m;
            rv_pkg::wb_imm: result_m = imm_m;
            default:        result_m = alu_m;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_w <= 1'b0;
            wb_sel_w    <= rv_pkg::wb_alu;
            rd_w        <= '0;
        end else begin
            reg_write_w <= reg_write_m;
            wb_sel_w    <= wb_sel_m;
            rd_w        <= rd_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_w <= alu_m;
        pc4_w <= pc4_m;
        imm_w <= imm_m;
    end

    always_comb begin
        case (wb_sel_w)
            rv_pkg::wb_mem: wd_w = dmem_rdata;  // registered read lands in writeback
            rv_pkg::wb_pc4: wd_w = pc4_w;
            rv_pkg::wb_imm: wd_w = imm_w;
            default:        wd_w = alu_w;
        endcase
    end

endmodule

// File: testbench/rv_core_assertions.sv
`timescale 1ns/100ps

module rv_core_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic [rv_pkg::xlen-1:0]   imem_addr,
    input logic [rv_pkg::xlen-1:0]   dmem_addr,
    input logic                      dmem_we
);

    int fail_count = 0; // failures seen so far

    imem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr is not word aligned");
            fail_count++;
        end

    // covers every reset cycle and the first one after release
    no_store_in_reset: assert property (@(posedge clk) !rst_n |=> !dmem_we)
        else begin
            $error("dmem_we high during or right after reset");
            fail_count++;
        end

    first_fetch: assert property (@(posedge clk) $rose(rst_n) |-> imem_addr == rv_pkg::reset_pc)
        else begin
            $error("first fetch after reset is not at the reset pc");
            fail_count++;
        end

    store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> dmem_addr[1:0] == 2'b00)
        else begin
            $error("store to an address that is not word aligned");
            fail_count++;
        end

    we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(dmem_we))
        else begin
            $error("dmem_we is unknown");
            fail_count++;
        end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we)
);

// File: testbench/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

    localparam int          halt_addr = 'h3fc;
    localparam logic [11:0] marker    = 12'h5a7;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] rdata_q;

    int          seed;
    int          n_instr;
    int          err_count;
    string       exp_name [$];
    int          exp_addr [$];
    logic [31:0] exp_val [$];

    rv_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memories

    assign imem_data = imem[imem_addr[9:2]];   // combinational fetch

    always @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        rdata_q <= dmem[dmem_addr[9:2]];
    end

    always @(negedge clk)
        dmem_rdata <= rdata_q;                 // read data valid in writeback

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc0de_0000 | 32'(idx * 4);   // tracks the byte address
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding, rv32i formats

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_r};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    // beq only
    function automatic logic [31:0] b_type(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
    endfunction

    function automatic logic [31:0] sign_ext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_instr] = word;
        n_instr++;
    endtask

    task automatic expect_at(input string name, input int addr, input logic [31:0] val);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_val.push_back(val);
    endtask

    task automatic check_word(input string name, input int addr, input logic [31:0] want);
        logic [31:0] got;
        got = dmem[addr[9:2]];
        if (got !== want) begin
            $display("ERR %s expected %h actual %h", name, want, got);
            err_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program and expected memory image

    task automatic build_program();
        logic [31:0] rnd, a, b, pj, nop;
        logic [11:0] ia, ib, ic, id1, id2, id3;
        logic [19:0] iu;
        rnd = $random(seed);
        ia  = rnd[11:0];
        ib  = rnd[23:12];
        rnd = $random(seed);
        ic  = rnd[11:0];
        iu  = rnd[31:12];
        rnd = $random(seed);
        id1 = rnd[11:0];
        id2 = rnd[23:12];
        rnd = $random(seed);
        id3 = rnd[11:0];
        a   = sign_ext12(ia);
        b   = sign_ext12(ib);
        nop = i_type(rv_pkg::op_imm, 3'b000, 5'd0, 5'd0, 12'd0);

        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd1, 5'd0, ia));
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd2, 5'd0, ib));
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));          // add
        emit(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));          // sub
        emit(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));          // and
        emit(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));          // or
        emit(r_type(7'h00, 3'b010, 5'd7, 5'd1, 5'd2));          // slt
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd8, 5'd1, ic));
        for (int k = 3; k <= 8; k++)
            emit(s_type(5'(k), 5'd0, 12'(256 + 4 * (k - 3))));
        expect_at("add", 'h100, a + b);
        expect_at("sub", 'h104, a - b);
        expect_at("and", 'h108, a & b);
        expect_at("or", 'h10c, a | b);
        // signs differ, the negative one is less
        expect_at("slt", 'h110, (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b});
        expect_at("addi", 'h114, a + sign_ext12(ic));

        // producer one, two and three slots ahead of its user
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd10, 5'd0, id1));
        emit(r_type(7'h00, 3'b000, 5'd11, 5'd10, 5'd10));
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd12, 5'd0, id2));
        emit(nop);
        emit(r_type(7'h00, 3'b000, 5'd13, 5'd12, 5'd12));
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd14, 5'd0, id3));
        emit(nop);
        emit(nop);
        emit(r_type(7'h00, 3'b000, 5'd15, 5'd14, 5'd14));
        emit(s_type(5'd11, 5'd0, 12'h120));
        emit(s_type(5'd13, 5'd0, 12'h124));
        emit(s_type(5'd15, 5'd0, 12'h128));
        expect_at("fwd_dist1", 'h120, sign_ext12(id1) * 2);
        expect_at("fwd_dist2", 'h124, sign_ext12(id2) * 2);
        expect_at("fwd_dist3", 'h128, sign_ext12(id3) * 2);

        // load then immediate use
        emit(s_type(5'd1, 5'd0, 12'h130));
        emit(i_type(rv_pkg::op_load, 3'b010, 5'd16, 5'd0, 12'h130));
        emit(r_type(7'h00, 3'b000, 5'd17, 5'd16, 5'd2));
        emit(s_type(5'd17, 5'd0, 12'h134));
        expect_at("load_use", 'h134, a + b);

        emit(b_type(5'd1, 5'd1, 13'd8));                       // taken
        emit(s_type(5'd1, 5'd0, 12'h140));                     // shadow
        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd18, 5'd0, 12'd1));
        emit(b_type(5'd18, 5'd0, 13'd8));                      // not taken, x18 just written
        emit(s_type(5'd18, 5'd0, 12'h144));
        emit(i_type(rv_pkg::op_load, 3'b010, 5'd19, 5'd0, 12'h130));
        emit(b_type(5'd19, 5'd1, 13'd8));                      // taken on loaded value
        emit(s_type(5'd2, 5'd0, 12'h148));                     // shadow
        emit(s_type(5'd19, 5'd0, 12'h14c));
        expect_at("beq_taken_shadow", 'h140, fill_word('h140 / 4));
        expect_at("beq_not_taken", 'h144, 32'd1);
        expect_at("beq_load_shadow", 'h148, fill_word('h148 / 4));
        expect_at("beq_load_target", 'h14c, a);

        pj = 32'(4 * n_instr);
        emit(j_type(5'd21, 21'd12));                           // jumps over two stores
        emit(s_type(5'd1, 5'd0, 12'h150));
        emit(s_type(5'd2, 5'd0, 12'h154));
        emit(s_type(5'd21, 5'd0, 12'h158));
        emit(u_type(5'd22, iu));
        emit(s_type(5'd22, 5'd0, 12'h15c));
        expect_at("jal_gap0", 'h150, fill_word('h150 / 4));
        expect_at("jal_gap1", 'h154, fill_word('h154 / 4));
        expect_at("jal_link", 'h158, pj + 4);
        expect_at("lui", 'h15c, {iu, 12'h000});

        emit(i_type(rv_pkg::op_imm, 3'b000, 5'd23, 5'd0, marker));
        emit(s_type(5'd23, 5'd0, 12'(halt_addr)));
        expect_at("halt", halt_addr, sign_ext12(marker));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run

    initial begin
        seed       = 32'h06f6_76f1;
        rst_n      = 1'b0;
        dmem_rdata = '0;
        n_instr    = 0;
        err_count  = 0;
        for (int k = 0; k < 256; k++) begin
            imem[k] = '0;
            dmem[k] = fill_word(k);
        end
        build_program();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        do @(negedge clk);
        while (!(dmem_we && dmem_addr == halt_addr));
        @(negedge clk);                       // halt store lands on the edge between

        for (int k = 0; k < exp_name.size(); k++)
            check_word(exp_name[k], exp_addr[k], exp_val[k]);
        $display("errors: compare=%0d assertion=%0d",
                 err_count, u_core.u_assertions.fail_count);
        if (err_count == 0 && u_core.u_assertions.fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // about three cycles per instruction is ample, stalls included
    initial begin
        wait (rst_n === 1'b1);
        repeat (n_instr * 3 + 50) @(posedge clk);
        $display("timeout: no halt store within %0d cycles", n_instr * 3 + 50);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: rv_core.f
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_imm_gen.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_hazard_unit.sv
logic/rv_core.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv
